//--- filelist.f
+incdir+logic
logic/sifhPkg.sv
logic/frameSequencer.sv
logic/histUpdater.sv
logic/peakTracker.sv
logic/sifhTop.sv
tests/clockGen.sv
tests/sifhTb.sv

//--- logic/frameSequencer.sv
`include "sifhConsts.svh"

module frameSequencer import sifhPkg::*; (
    input  logic      clk,
    input  logic      rstN,
    input  logic      wrEn,
    input  logic      ready,
    output logic      accept,
    output sampleTagT tag
);

    // sample index inside the current pixel
    logic [`DATA_W-1:0] sampleCnt;
    // current pixel of the sequence
    pixelT pixelCnt;
    // acquisition index inside the frame
    logic [`ACQ_W-1:0] acqCnt;

    logic lastSample;
    logic lastPixel;
    logic lastAcq;

    // strobe only counts while the updater is ready
    assign accept = wrEn & ready;

    assign lastSample = (int'(sampleCnt) == `DATA_NUM - 1);
    assign lastPixel  = (int'(pixelCnt) == `PIXEL_NUM - 1);
    assign lastAcq    = (int'(acqCnt) == `ACQ_NUM - 1);

    // tag is valid in the accept cycle itself
    assign tag.pixel       = pixelCnt;
    assign tag.lastOfFrame = lastSample & lastPixel & lastAcq;

    // nested counters: sample, then pixel, then acquisition
    always_ff @(posedge clk) begin
        if (!rstN) begin
            sampleCnt <= '0;
            pixelCnt  <= '0;
            acqCnt    <= '0;
        end else if (accept) begin
            if (lastSample) begin
                sampleCnt <= '0;
                if (lastPixel) begin
                    pixelCnt <= '0;
                    // wraps to zero after the last acquisition
                    if (lastAcq) begin
                        acqCnt <= '0;
                    end else begin
                        acqCnt <= acqCnt + 1'b1;
                    end
                end else begin
                    pixelCnt <= pixelCnt + 1'b1;
                end
            end else begin
                sampleCnt <= sampleCnt + 1'b1;
            end
        end
    end

    // pixel tag must stay inside the RAM's pixel range
    pixelRange: assert property (
        @(posedge clk) disable iff (!rstN)
        int'(tag.pixel) < `PIXEL_NUM
    );

endmodule

//--- logic/histUpdater.sv
`include "sifhConsts.svh"

module histUpdater import sifhPkg::*; (
    input  logic      clk,
    input  logic      rstN,
    input  logic      accept,
    input  timestampT data,
    input  sampleTagT tag,
    output logic      ready,
    output logic      updValid,
    output binUpdateT upd
);

    // histograms of all pixels, address is {pixel, bin}
    countT histRam [`RAM_DEPTH];

    updState state;
    logic [`ADDR_W-1:0] clrAddr;

    // stage one: address registered, RAM read
    logic               s1Valid;
    logic [`ADDR_W-1:0] s1Addr;
    logic               s1Last;
    countT              s1Base;

    // stage two: increment and write back
    logic               s2Valid;
    logic [`ADDR_W-1:0] s2Addr;
    logic               s2Last;
    countT              s2Base;
    countT              s2New;

    // bin taken from the top bits of the timestamp
    always_ff @(posedge clk) begin
        s1Addr <= {tag.pixel, data[`NP-1 -: `NB]};
        s1Last <= tag.lastOfFrame;
    end

    // forward from stage two when it holds the same address,
    // its write has not reached the RAM yet
    assign s1Base = (s2Valid && (s2Addr == s1Addr)) ? s2New : histRam[s1Addr];

    always_ff @(posedge clk) begin
        s2Addr <= s1Addr;
        s2Last <= s1Last;
        s2Base <= s1Base;
    end

    // saturate at all ones
    assign s2New = (s2Base == '1) ? s2Base : s2Base + 1'b1;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            s1Valid <= 1'b0;
            s2Valid <= 1'b0;
        end else begin
            s1Valid <= accept;
            s2Valid <= s1Valid;
        end
    end

    // single write port, sweep wins over late updates of a finished frame
    always_ff @(posedge clk) begin
        if (state == CLEARING) begin
            histRam[clrAddr] <= '0;
        end else if (s2Valid) begin
            histRam[s2Addr] <= s2New;
        end
    end

    // clear sweep after reset and after the last sample of a frame
    always_ff @(posedge clk) begin
        if (!rstN) begin
            state   <= CLEARING;
            clrAddr <= '0;
        end else begin
            case (state)
                CLEARING: begin
                    if (int'(clrAddr) == `RAM_DEPTH - 1) begin
                        clrAddr <= '0;
                        state   <= RUNNING;
                    end else begin
                        clrAddr <= clrAddr + 1'b1;
                    end
                end
                RUNNING: begin
                    // ready drops the cycle after the last accept
                    if (accept && tag.lastOfFrame) begin
                        state <= CLEARING;
                    end
                end
                default: state <= CLEARING;
            endcase
        end
    end

    assign ready = (state == RUNNING);

    // new count leaves two cycles after the accept
    assign updValid        = s2Valid;
    assign upd.pixel       = s2Addr[`ADDR_W-1 -: `PIX_W];
    assign upd.bin         = s2Addr[`NB-1:0];
    assign upd.count       = s2New;
    assign upd.lastOfFrame = s2Last;

    // sequencer must never accept during the sweep
    noAcceptInClear: assert property (
        @(posedge clk) disable iff (!rstN)
        accept |-> (state == RUNNING)
    );

endmodule

//--- logic/peakTracker.sv
`include "sifhConsts.svh"

module peakTracker import sifhPkg::*; (
    input  logic       clk,
    input  logic       rstN,
    input  logic       updValid,
    input  binUpdateT  upd,
    output logic       peakValid,
    output peakResultT peak
);

    // running peak of each pixel
    binT   bestBin   [`PIXEL_NUM];
    countT bestCount [`PIXEL_NUM];

    seqState state;
    // pixel being streamed out
    pixelT rdPix;

    logic lastRd;
    logic newPeak;

    assign lastRd = (int'(rdPix) == `PIXEL_NUM - 1);

    // strictly greater, so on a tie the earlier bin is kept
    assign newPeak = updValid && (upd.count > bestCount[upd.pixel]);

    // readout of the frame's peaks
    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= IDLE;
            rdPix <= '0;
        end else begin
            case (state)
                IDLE: begin
                    // last update is stored this cycle, stream from next
                    if (updValid && upd.lastOfFrame) begin
                        state <= STREAM;
                        rdPix <= '0;
                    end
                end
                STREAM: begin
                    if (lastRd) begin
                        state <= IDLE;
                        rdPix <= '0;
                    end else begin
                        rdPix <= rdPix + 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // peak table, zeroed once all results are out
    always_ff @(posedge clk) begin
        if (!rstN || ((state == STREAM) && lastRd)) begin
            for (int i = 0; i < `PIXEL_NUM; i++) begin
                bestBin[i]   <= '0;
                bestCount[i] <= '0;
            end
        end else if (newPeak) begin
            bestBin[upd.pixel]   <= upd.bin;
            bestCount[upd.pixel] <= upd.count;
        end
    end

    // results in pixel order 0, 1, 2
    assign peakValid  = (state == STREAM);
    assign peak.pixel = rdPix;
    assign peak.bin   = bestBin[rdPix];
    assign peak.count = bestCount[rdPix];

    // exactly one burst of PIXEL_NUM results per frame end
    burstLength: assert property (
        @(posedge clk) disable iff (!rstN)
        peakValid [* `PIXEL_NUM] |=> !peakValid
    );

endmodule

//--- logic/sifhConsts.svh
`ifndef SIFH_CONSTS_SVH
`define SIFH_CONSTS_SVH

// timestamp width from the TDC
`define NP 10
// bin index width, top bits of the timestamp
`define NB 3
// histogram count width, saturates at all ones
`define PEAK_MAX 4

// sensor sequence sizes
`define PIXEL_NUM 3
`define DATA_NUM 2
`define ACQ_NUM 8

// derived widths
`define PIX_W 2
`define DATA_W 1
`define ACQ_W 3
`define ADDR_W (`PIX_W + `NB)
`define RAM_DEPTH (`PIXEL_NUM * (1 << `NB))

`endif

//--- logic/sifhPkg.sv
`include "sifhConsts.svh"

package sifhPkg;

    // raw timestamp as strobed in
    typedef logic [`NP-1:0] timestampT;
    // histogram bin index
    typedef logic [`NB-1:0] binT;
    // saturating bin count
    typedef logic [`PEAK_MAX-1:0] countT;
    // pixel index within one RAM
    typedef logic [`PIX_W-1:0] pixelT;

    // tag attached to each accepted sample
    typedef struct packed {
        pixelT pixel;
        logic  lastOfFrame;
    } sampleTagT;

    // new count of one bin, leaving the updater
    typedef struct packed {
        pixelT pixel;
        binT   bin;
        countT count;
        logic  lastOfFrame;
    } binUpdateT;

    // one peak result per pixel at frame end
    typedef struct packed {
        pixelT pixel;
        binT   bin;
        countT count;
    } peakResultT;

    // updater: clear sweep or normal histogramming
    typedef enum logic {CLEARING, RUNNING} updState;
    // tracker: waiting for frame end or streaming results
    typedef enum logic {IDLE, STREAM} seqState;

endpackage

//--- logic/sifhTop.sv
module sifhTop import sifhPkg::*; (
    input  logic       clk,
    input  logic       rstN,
    input  logic       wrEn,
    input  timestampT  data,
    output logic       ready,
    output logic       peakValid,
    output peakResultT peak
);

    // accepted sample and its pixel tag
    logic      accept;
    sampleTagT tag;

    // new bin counts towards the tracker
    logic      updValid;
    binUpdateT upd;

    // pixel and frame position of each sample
    frameSequencer sequencer (
        .clk    (clk),
        .rstN   (rstN),
        .wrEn   (wrEn),
        .ready  (ready),
        .accept (accept),
        .tag    (tag)
    );

    // histogram RAM and clear sweep, owns ready
    histUpdater updater (
        .clk      (clk),
        .rstN     (rstN),
        .accept   (accept),
        .data     (data),
        .tag      (tag),
        .ready    (ready),
        .updValid (updValid),
        .upd      (upd)
    );

    // per-pixel peak search and result stream
    peakTracker tracker (
        .clk       (clk),
        .rstN      (rstN),
        .updValid  (updValid),
        .upd       (upd),
        .peakValid (peakValid),
        .peak      (peak)
    );

endmodule

//--- run.sh
#!/usr/bin/env bash
# compile the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module sifhTb \
    -f filelist.f -o sifhSim \
    && ./obj_dir/sifhSim | tee /dev/stderr | grep -q "TEST PASSED" \
    && echo "simulation finished without errors" \
    || { echo "simulation reported a failure"; exit 1; }

//--- tests/clockGen.sv
module clockGen (
    output logic clk
);

    timeunit 1ns;
    timeprecision 100ps;

    // half of the 100 ns period
    localparam int halfPeriod = 50;

    initial begin
        clk = 1'b0;
        forever begin
            #halfPeriod;
            clk = ~clk;
        end
    end

endmodule

//--- tests/sifhCases.txt
# S wrEn t0 t1 t2 t3 t4 t5: one acquisition, hex timestamps for pixel 0, 0, 1, 1, 2, 2
# I cycles t: strobes during the clear sweep; E pixel bin count: expected peak, decimal
#
# frame one
# pixel 0: all 16 samples in bin 5, back to back, count saturates at 15
# pixel 1: bins 2 and 6 tie at 6, bin 6 got there first
# pixel 2: bin 3 wins with 9
S 1 2A3 2F0 305 37F 1A0 3C2
S 1 281 2C4 10F 155 1B7 1FF
S 1 2D9 2A0 340 17E 012 1C8
S 1 2FF 280 123 366 3E1 189
S 1 2B5 2B5 300 33C 1D4 07F
S 1 2E8 291 100 16A 3FF 1C0
S 1 2C0 2C1 045 0AB 199 03A
S 1 29E 2A7 070 0C9 3B2 1EE
# strobes while ready is low, must not count or shift the pixel tags
I 5 3FF
E 0 5 15
E 1 6 6
E 2 3 9
#
# frame two, no carry-over from frame one
# pixel 0: bin 1 wins with 7, bin 5 only 5
# pixel 1: bin 4 wins with 6, bin 6 only 5
# pixel 2: bin 2 wins with 8, bin 3 only 3
S 1 0A1 2B3 31A 004 101 17F
S 1 080 0FE 240 23F 3C5 1A9
S 1 211 2C8 377 05B 12C 391
S 1 0D0 25A 266 350 160 160
# wrEn low while ready is high, nothing counted
S 0 3FF 3FF 3FF 3FF 3FF 3FF
S 1 2E1 09C 01C 202 1F3 3FE
S 1 27F 290 30C 071 144 388
S 1 0B5 200 219 36D 15D 180
S 1 2AA 0C3 000 27E 3D7 133
E 0 1 7
E 1 4 6
E 2 2 8

//--- tests/sifhTb.sv
`include "sifhConsts.svh"

module sifhTb import sifhPkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    // samples in one full frame
    localparam int frameLen = `PIXEL_NUM * `DATA_NUM * `ACQ_NUM;
    localparam int waitLimit = 100;
    // a bin count stops at all ones
    localparam int countMax = (1 << `PEAK_MAX) - 1;

    logic       clk;
    logic       rstN;
    logic       wrEn;
    timestampT  data;
    logic       ready;
    logic       peakValid;
    peakResultT peak;

    int seed = 98;
    int checks = 0;
    int valueErrors = 0;
    int otherErrors = 0;
    logic aborted = 1'b0;

    // monitor state
    int cycle = 0;
    int accepted = 0;
    int lastAccept = -100;
    logic prevValid = 1'b0;
    peakResultT results[$];

    // reference histogram of the running frame, pixel * 8 + bin
    int modelHist[`RAM_DEPTH];
    int modelAddr;
    // expected count and due cycle of each bin update in flight
    countT updExpected[$];
    int updDue[$];

    clockGen clkGen (.clk(clk));

    sifhTop dut (
        .clk       (clk),
        .rstN      (rstN),
        .wrEn      (wrEn),
        .data      (data),
        .ready     (ready),
        .peakValid (peakValid),
        .peak      (peak)
    );

    task automatic checkCount(input string name, input countT expected, input countT actual);
        checks++;
        if (actual !== expected) begin
            valueErrors++;
            $display("[ERROR] %0t %s expected %0d actual %0d", $time, name, expected, actual);
        end
    endtask

    task automatic checkPeak(input peakResultT expected, input peakResultT actual);
        checks++;
        if (actual.pixel !== expected.pixel) begin
            valueErrors++;
            $display("[ERROR] %0t peak.pixel expected %0d actual %0d",
                $time, expected.pixel, actual.pixel);
        end
        checks++;
        if (actual.bin !== expected.bin) begin
            valueErrors++;
            $display("[ERROR] %0t peak.bin expected %0d actual %0d",
                $time, expected.bin, actual.bin);
        end
        checkCount("peak.count", expected.count, actual.count);
    endtask

    // inputs change 10 ns after the rising edge
    task automatic nextCycle();
        @(posedge clk);
        #10;
    endtask

    task automatic idleCycle();
        nextCycle();
        wrEn = 1'b0;
    endtask

    // one sample, after a random idle gap where asked, once the updater is ready
    task automatic driveSample(input logic en, input logic gapBefore, input timestampT value);
        int gap;
        int waited;
        if (gapBefore) begin
            gap = $unsigned($random(seed)) % 3;
            repeat (gap) idleCycle();
        end
        nextCycle();
        waited = 0;
        while (en && !ready && waited < waitLimit) begin
            wrEn = 1'b0;
            nextCycle();
            waited++;
        end
        if (en && !ready) begin
            $display("timeout: ready stayed low for %0d cycles", waitLimit);
            aborted = 1'b1;
        end else begin
            wrEn = en;
            data = value;
        end
    endtask

    // strobes that must fall into the clear sweep
    task automatic driveIgnored(input int n, input timestampT value);
        for (int i = 0; i < n; i++) begin
            nextCycle();
            if (ready) begin
                otherErrors++;
                $display("ready was already high where a strobe was meant to be ignored");
                wrEn = 1'b0;
            end else begin
                wrEn = 1'b1;
                data = value;
            end
        end
    endtask

    task automatic expectPeak(input peakResultT expected);
        int waited;
        waited = 0;
        while (results.size() == 0 && waited < waitLimit) begin
            idleCycle();
            waited++;
        end
        if (results.size() == 0) begin
            $display("timeout: no peak result arrived within %0d cycles", waitLimit);
            aborted = 1'b1;
        end else begin
            checkPeak(expected, results.pop_front());
        end
    endtask

    task automatic runLine(input string line);
        int en;
        int v[6];
        int pix;
        int bin;
        int cnt;
        int code;
        peakResultT expected;
        case (line.getc(0))
            "S": begin
                code = $sscanf(line, "S %d %h %h %h %h %h %h",
                    en, v[0], v[1], v[2], v[3], v[4], v[5]);
                if (code != 7) begin
                    $display("malformed stimulus line in the cases file");
                    aborted = 1'b1;
                end
                // samples of one pixel stay back to back, gaps fall between pixels
                for (int i = 0; i < 6 && !aborted; i++) begin
                    driveSample(en != 0, (i % `DATA_NUM) == 0, timestampT'(v[i]));
                end
            end
            "I": begin
                code = $sscanf(line, "I %d %h", en, v[0]);
                driveIgnored(en, timestampT'(v[0]));
            end
            "E": begin
                code = $sscanf(line, "E %d %d %d", pix, bin, cnt);
                expected.pixel = pixelT'(pix);
                expected.bin   = binT'(bin);
                expected.count = countT'(cnt);
                expectPeak(expected);
            end
            default: begin
            end
        endcase
    endtask

    // mid-cycle view of accepts, bin updates and results
    always @(negedge clk) begin
        cycle++;
        // each bin update answers the oldest accepted sample, two cycles later
        if (rstN && dut.updValid) begin
            if (updExpected.size() == 0) begin
                otherErrors++;
                $display("a bin update appeared without an accepted sample behind it");
            end else begin
                if (updDue.pop_front() != cycle) begin
                    otherErrors++;
                    $display("a bin update did not come two cycles after its sample");
                end
                checkCount("upd.count", updExpected.pop_front(), dut.upd.count);
            end
        end
        if (rstN && wrEn && ready) begin
            modelAddr = ((accepted / `DATA_NUM) % `PIXEL_NUM) * (1 << `NB)
                + int'(data[`NP-1 -: `NB]);
            if (modelHist[modelAddr] < countMax) begin
                modelHist[modelAddr]++;
            end
            updExpected.push_back(countT'(modelHist[modelAddr]));
            updDue.push_back(cycle + 2);
            accepted++;
            if (accepted % frameLen == 0) begin
                lastAccept = cycle;
                // RAM is swept to zero after the frame's last sample
                foreach (modelHist[i]) begin
                    modelHist[i] = 0;
                end
            end
        end
        if (cycle == lastAccept + 1 && ready) begin
            otherErrors++;
            $display("ready did not fall the cycle after the last sample of a frame");
        end
        if (peakValid) begin
            // first result of a burst comes 3 cycles after the frame's last sample
            if (!prevValid && cycle != lastAccept + 3) begin
                otherErrors++;
                $display("peak burst started at the wrong cycle after the frame end");
            end
            results.push_back(peak);
        end
        prevValid = peakValid;
    end

    initial begin
        string line;
        int fd;
        int code;
        rstN = 1'b0;
        wrEn = 1'b0;
        data = '0;
        repeat (5) @(posedge clk);
        #10;
        rstN = 1'b1;
        fd = $fopen("tests/sifhCases.txt", "r");
        if (fd == 0) begin
            $display("cannot open the cases file");
            aborted = 1'b1;
        end
        while (!aborted && !$feof(fd)) begin
            code = $fgets(line, fd);
            if (code > 0) begin
                runLine(line);
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        // a few quiet cycles to catch surplus results
        repeat (4) idleCycle();
        if (!aborted && results.size() != 0) begin
            otherErrors++;
            $display("more peak results arrived than the cases file expects");
        end
        $display("checks %0d, value errors %0d, other errors %0d, aborted %0d",
            checks, valueErrors, otherErrors, aborted);
        if (!aborted && valueErrors == 0 && otherErrors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
